// File: attn_cfg.svh
/*
 * Attention score path configuration
 * Widths, lengths and scaling shared by every stage
 */
`ifndef ATTN_CFG_SVH
`define ATTN_CFG_SVH

// Input vectors
`define ATTN_ELEM_W      8
`define ATTN_DIM         4
`define ATTN_SEQ_LEN     8
`define ATTN_IDX_W       3

// Dot product and scaled score
`define ATTN_ACC_W       18
`define ATTN_SCORE_W     16
`define ATTN_SCORE_SHIFT 2

// Softmax terms, probability is Q1.15
`define ATTN_EXP_W       16
`define ATTN_PROB_W      16
`define ATTN_PROB_FRAC   15
`define ATTN_SUM_W       19

// Restoring divider, dividend width and step counter
`define ATTN_DIV_W       32
`define ATTN_DIV_CNT_W   6

`endif

// File: attn_pkg.sv
/*
 * Attention score path types
 * Element, score and probability words, port payloads and softmax states
 */
`default_nettype none
`include "attn_cfg.svh"

package attn_pkg;

    typedef logic signed [`ATTN_ELEM_W-1:0]  elem_t;
    typedef elem_t [`ATTN_DIM-1:0]           vec_t;
    typedef logic signed [`ATTN_SCORE_W-1:0] score_t;
    typedef logic [`ATTN_EXP_W-1:0]          exp_t;
    typedef logic [`ATTN_SUM_W-1:0]          sum_t;
    typedef logic [`ATTN_PROB_W-1:0]         prob_t;
    typedef logic [`ATTN_IDX_W-1:0]          idx_t;

    // One input transaction, q repeated with each key
    typedef struct packed {
        vec_t q;
        vec_t k;
    } qk_beat_t;

    // One output transaction
    typedef struct packed {
        prob_t p;
        idx_t  idx;
        logic  last;
    } prob_beat_t;

    typedef score_t [`ATTN_SEQ_LEN-1:0] score_row_t;

    typedef enum logic [2:0] {
        IDLE,
        MAX,
        EXP,
        DIV,
        SEND
    } smax_state_t;

endpackage

`default_nettype wire

// File: score_matmul.sv
/*
 * Score stage: four-phase key input, q.k dot product and arithmetic scaling shift
 */
`default_nettype none
`include "attn_cfg.svh"

module score_matmul (
    input  logic               clk,
    input  logic               rst_n,
    input  attn_pkg::qk_beat_t in_beat,
    input  logic               in_req,
    output logic               in_ack,
    input  logic               buf_full,
    output attn_pkg::score_t   score,
    output logic               score_valid
);
    import attn_pkg::*;

    qk_beat_t beat_q;
    logic     beat_valid;
    logic     prod_valid;
    logic     busy;
    logic     take;

    logic signed [2*`ATTN_ELEM_W-1:0] prod_q [`ATTN_DIM];
    logic signed [`ATTN_ACC_W-1:0]    acc;

    // Single slot, so nothing new enters while a score is still in flight
    assign busy = beat_valid | prod_valid | score_valid;
    assign take = in_req & ~in_ack & ~buf_full & ~busy;

    // Four-phase ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (take) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            // Host has dropped req, close the transaction
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            beat_q <= in_beat;
        end
    end

    // Valid follows the data through capture, multiply and sum
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_valid  <= 1'b0;
            prod_valid  <= 1'b0;
            score_valid <= 1'b0;
        end else begin
            beat_valid  <= take;
            prod_valid  <= beat_valid;
            score_valid <= prod_valid;
        end
    end

    // Element products
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int i = 0; i < `ATTN_DIM; i++) begin
                prod_q[i] <= $signed(beat_q.q[i]) * $signed(beat_q.k[i]);
            end
        end
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            acc = acc + prod_q[i];
        end
    end

    // Arithmetic shift floors toward minus infinity
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            score <= score_t'(acc >>> `ATTN_SCORE_SHIFT);
        end
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose while in_req was low");

endmodule

`default_nettype wire

// File: row_buffer.sv
/*
 * Row buffer: gathers SEQ_LEN scores in arrival order into one softmax row
 */
`default_nettype none
`include "attn_cfg.svh"

module row_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::score_t     score,
    input  logic                 score_valid,
    output logic                 buf_full,
    output attn_pkg::score_row_t row,
    output logic                 row_valid,
    input  logic                 row_take
);
    import attn_pkg::*;

    idx_t wr_idx;
    logic full_q;
    logic wr_en;

    assign wr_en     = score_valid & ~full_q;
    assign buf_full  = full_q;
    assign row_valid = full_q;

    // Write pointer and row complete flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx <= '0;
            full_q <= 1'b0;
        end else if (full_q) begin
            if (row_take) begin
                full_q <= 1'b0;
            end
        end else if (wr_en) begin
            // Wraps back to slot 0 for the next row
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == idx_t'(`ATTN_SEQ_LEN - 1)) begin
                full_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            row[wr_idx] <= score;
        end
    end

    // Upstream must hold off once the row is complete
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        score_valid |-> !buf_full
    ) else $error("score_valid arrived while the row buffer was full");

endmodule

`default_nettype wire

// File: softmax_row.sv
/*
 * Row softmax: base-2 exponent terms, restoring divide per element,
 * probabilities out through a four-phase port
 */
`default_nettype none
`include "attn_cfg.svh"

module softmax_row (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::score_row_t row,
    input  logic                 row_valid,
    output logic                 row_take,
    output attn_pkg::prob_beat_t out_beat,
    output logic                 out_req,
    input  logic                 out_ack
);
    import attn_pkg::*;

    smax_state_t state;
    idx_t        idx;
    logic [`ATTN_DIV_CNT_W-1:0] cnt;
    logic        last_elem;

    score_row_t  row_q;
    score_t      max_q;
    exp_t        e_q [`ATTN_SEQ_LEN];
    sum_t        sum_q;
    logic [`ATTN_SUM_W-1:0] rem_q;
    logic [`ATTN_DIV_W-1:0] quo_q;

    score_t      cur;
    logic signed [`ATTN_SCORE_W:0] diff;
    exp_t        e_next;
    logic [`ATTN_SUM_W:0] rem_sh;
    logic [`ATTN_SUM_W:0] rem_diff;
    logic        rem_ge;

    assign last_elem = (idx == idx_t'(`ATTN_SEQ_LEN - 1));

    always_comb begin
        cur  = row_q[idx];
        diff = max_q - cur;
        // 2^15 >> d, vanishes once d reaches 16
        if (diff >= (`ATTN_PROB_FRAC + 1)) begin
            e_next = '0;
        end else begin
            e_next = (exp_t'(1) << `ATTN_PROB_FRAC) >> diff[3:0];
        end
    end

    // One restoring divide step
    assign rem_sh   = {rem_q, quo_q[`ATTN_DIV_W-1]};
    assign rem_diff = rem_sh - {1'b0, sum_q};
    assign rem_ge   = (rem_sh >= {1'b0, sum_q});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            idx      <= '0;
            cnt      <= '0;
            row_take <= 1'b0;
            out_req  <= 1'b0;
        end else begin
            row_take <= 1'b0;
            case (state)
                IDLE: begin
                    if (row_valid) begin
                        row_q    <= row;
                        row_take <= 1'b1;
                        idx      <= '0;
                        state    <= MAX;
                    end
                end
                MAX: begin
                    if (idx == '0 || cur > max_q) begin
                        max_q <= cur;
                    end
                    idx <= idx + 1'b1;
                    if (last_elem) begin
                        state <= EXP;
                    end
                end
                EXP: begin
                    e_q[idx] <= e_next;
                    sum_q    <= (idx == '0) ? sum_t'(e_next) : sum_q + e_next;
                    idx      <= idx + 1'b1;
                    if (last_elem) begin
                        cnt   <= '0;
                        state <= DIV;
                    end
                end
                DIV: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == '0) begin
                        // Dividend is e_j scaled by 2^15
                        rem_q <= '0;
                        quo_q <= {{(`ATTN_DIV_W - `ATTN_EXP_W - `ATTN_PROB_FRAC){1'b0}},
                                  e_q[idx], {`ATTN_PROB_FRAC{1'b0}}};
                    end else if (cnt == (`ATTN_DIV_W + 1)) begin
                        out_beat.p    <= quo_q[`ATTN_PROB_W-1:0];
                        out_beat.idx  <= idx;
                        out_beat.last <= last_elem;
                        out_req       <= 1'b1;
                        state         <= SEND;
                    end else begin
                        rem_q <= rem_ge ? rem_diff[`ATTN_SUM_W-1:0] : rem_sh[`ATTN_SUM_W-1:0];
                        quo_q <= {quo_q[`ATTN_DIV_W-2:0], rem_ge};
                    end
                end
                SEND: begin
                    if (out_req && out_ack) begin
                        out_req <= 1'b0;
                    end else if (!out_req && !out_ack) begin
                        // Handshake closed, move on
                        cnt   <= '0;
                        idx   <= idx + 1'b1;
                        state <= last_elem ? IDLE : DIV;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    beat_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_beat)
    ) else $error("out_beat changed while out_req was high");

endmodule

`default_nettype wire

// File: attention_head.sv
/*
 * Attention head score path: matmul with scaling, row buffer, row softmax
 */
`default_nettype none

module attention_head (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::qk_beat_t   in_beat,
    input  logic                 in_req,
    output logic                 in_ack,
    output attn_pkg::prob_beat_t out_beat,
    input  logic                 out_ack,
    output logic                 out_req
);
    import attn_pkg::*;

    score_t     score;
    logic       score_valid;
    logic       buf_full;
    score_row_t row;
    logic       row_valid;
    logic       row_take;

    score_matmul matmul0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .buf_full    (buf_full),
        .score       (score),
        .score_valid (score_valid)
    );

    row_buffer rowbuf0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .score       (score),
        .score_valid (score_valid),
        .buf_full    (buf_full),
        .row         (row),
        .row_valid   (row_valid),
        .row_take    (row_take)
    );

    softmax_row smax0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row),
        .row_valid (row_valid),
        .row_take  (row_take),
        .out_beat  (out_beat),
        .out_req   (out_req),
        .out_ack   (out_ack)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
/*
 * Testbench clock source, period of 4 time units
 */
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tb_attention_head.sv
/*
 * Attention head testbench: directed, corner and random rows
 * checked against a softmax reference model, with random output back-pressure
 */
`default_nettype none
`include "attn_cfg.svh"

module tb_attention_head;
    import attn_pkg::*;

    localparam int     RESET_CYCLES  = 10;
    localparam int     NUM_ROWS      = 20;
    localparam int     NUM_BEATS     = NUM_ROWS * `ATTN_SEQ_LEN;
    localparam int     MAX_ACK_DELAY = 50;
    localparam longint EXP_ONE       = longint'(1) << `ATTN_PROB_FRAC;
    // Per element divide, worst ack and release delays and handshake, plus both scans
    localparam int     ROW_CYCLES    = `ATTN_SEQ_LEN * (34 + 2 * MAX_ACK_DELAY + 8) + 64;
    localparam int     LIMIT_CYCLES  = RESET_CYCLES + NUM_ROWS * ROW_CYCLES;

    logic       clk;
    logic       rst_n;
    qk_beat_t   in_beat;
    logic       in_req;
    logic       in_ack;
    prob_beat_t out_beat;
    logic       out_req;
    logic       out_ack;

    int         seed;
    int         ack_delay [NUM_BEATS];
    int         release_delay [NUM_BEATS];
    int         rows_out;
    prob_beat_t exp_queue [$];
    prob_beat_t exp_beat;

    tb_clock clock0 (
        .clk (clk)
    );

    attention_head dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .out_beat (out_beat),
        .out_ack  (out_ack),
        .out_req  (out_req)
    );

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Score reference, q.k then floor division by 2^SCORE_SHIFT
    function automatic int ref_score(input vec_t q, input vec_t k);
        int acc;
        acc = 0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            acc += int'(q[i]) * int'(k[i]);
        end
        return acc >>> `ATTN_SCORE_SHIFT;
    endfunction

    // Base-2 softmax over one row of scores
    task automatic model_probs(input int s [`ATTN_SEQ_LEN], output int p [`ATTN_SEQ_LEN]);
        int     m;
        longint e [`ATTN_SEQ_LEN];
        longint total;
        m = s[0];
        for (int j = 1; j < `ATTN_SEQ_LEN; j++) begin
            if (s[j] > m) begin
                m = s[j];
            end
        end
        total = 0;
        for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
            e[j] = (m - s[j] >= 16) ? 0 : (EXP_ONE >> (m - s[j]));
            total += e[j];
        end
        for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
            p[j] = int'((e[j] * EXP_ONE) / total);
        end
    endtask

    task automatic expect_row(input int p [`ATTN_SEQ_LEN]);
        prob_beat_t b;
        for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
            b.p    = prob_t'(p[j]);
            b.idx  = idx_t'(j);
            b.last = (j == `ATTN_SEQ_LEN - 1);
            exp_queue.push_back(b);
        end
    endtask

    // Host side of the four-phase input port, called on a falling edge
    task automatic send_beat(input qk_beat_t b);
        int hold;
        in_beat = b;
        in_req  = 1'b1;
        do @(negedge clk); while (in_ack !== 1'b1);
        // Keep req up a few cycles past ack
        hold = int'($unsigned($random(seed)) % 4);
        repeat (hold) @(negedge clk);
        in_req = 1'b0;
        do @(negedge clk); while (in_ack !== 1'b0);
    endtask

    task automatic send_row(input vec_t q, input vec_t keys [`ATTN_SEQ_LEN]);
        qk_beat_t b;
        for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
            b.q = q;
            b.k = keys[j];
            send_beat(b);
        end
    endtask

    task automatic run_model_row(input vec_t q, input vec_t keys [`ATTN_SEQ_LEN]);
        int s [`ATTN_SEQ_LEN];
        int p [`ATTN_SEQ_LEN];
        for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
            s[j] = ref_score(q, keys[j]);
        end
        model_probs(s, p);
        expect_row(p);
        send_row(q, keys);
    endtask

    function automatic vec_t random_vec(input bit full);
        vec_t v;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            if (full) begin
                v[i] = elem_t'($random(seed));
            end else begin
                v[i] = elem_t'($random(seed) % 6);
            end
        end
        return v;
    endfunction

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (in_ack === 1'b0 && out_req === 1'b0)
                else report_error("in_ack or out_req not low during reset");
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            assert (in_ack === 1'b0 && out_req === 1'b0)
                else report_error("in_ack or out_req not low after reset");
        end
    endtask

    // Each new output beat against the head of the expected queue
    beat_matches: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> out_beat == exp_beat
    ) else report_error($sformatf(
        "out_beat p=%0d idx=%0d last=%0b, expected p=%0d idx=%0d last=%0b",
        out_beat.p, out_beat.idx, out_beat.last, exp_beat.p, exp_beat.idx, exp_beat.last));

    // Four-phase ordering on both ports
    in_ack_rise: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> $past(in_req)
    ) else report_error("in_ack rose while in_req was low");

    in_ack_fall: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(in_ack) |-> !$past(in_req)
    ) else report_error("in_ack fell while in_req was still high");

    out_req_rise: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(out_req) |-> !$past(out_ack)
    ) else report_error("out_req rose while out_ack was still high");

    out_req_fall: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(out_req) |-> $past(out_ack)
    ) else report_error("out_req fell before out_ack arrived");

    // Host side of the output port, random ack and release delay per beat
    initial begin : ack_host
        int n;
        int row_sum;
        n        = 0;
        row_sum  = 0;
        rows_out = 0;
        exp_beat = '0;
        out_ack  = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req === 1'b1) begin
                assert (exp_queue.size() > 0)
                    else report_error("output beat arrived with no row pending");
                exp_beat = exp_queue.pop_front();
                row_sum += int'(out_beat.p);
                if (out_beat.last) begin
                    assert (row_sum >= EXP_ONE - 8 && row_sum <= EXP_ONE)
                        else report_error($sformatf("row %0d sums to %0d", rows_out, row_sum));
                    row_sum = 0;
                    rows_out++;
                end
                repeat (ack_delay[n % NUM_BEATS]) @(negedge clk);
                out_ack = 1'b1;
                do @(negedge clk); while (out_req !== 1'b0);
                // Ack stays up for a while after req drops
                repeat (release_delay[n % NUM_BEATS]) @(negedge clk);
                n++;
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: %0d rows not finished within %0d cycles", NUM_ROWS, LIMIT_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin : stimulus
        vec_t q;
        vec_t keys [`ATTN_SEQ_LEN];
        int   p [`ATTN_SEQ_LEN];
        seed    = 32'h8af96133;
        in_req  = 1'b0;
        in_beat = '0;
        for (int i = 0; i < NUM_BEATS; i++) begin
            ack_delay[i]     = int'($unsigned($random(seed)) % (MAX_ACK_DELAY + 1));
            release_delay[i] = int'($unsigned($random(seed)) % (MAX_ACK_DELAY + 1));
        end
        hold_reset();

        // Equal keys give a flat row
        for (int r = 0; r < 2; r++) begin
            q       = random_vec(1'b1);
            keys[0] = random_vec(1'b1);
            for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
                keys[j] = keys[0];
                p[j]    = 4096;
            end
            expect_row(p);
            send_row(q, keys);
        end

        // One score far above the rest takes the whole row
        for (int hot = 3; hot < `ATTN_SEQ_LEN; hot += 3) begin
            q    = '0;
            q[0] = elem_t'(64);
            for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
                keys[j] = random_vec(1'b0);
                p[j]    = 0;
            end
            keys[hot][0] = elem_t'(100);
            p[hot]       = 32768;
            expect_row(p);
            send_row(q, keys);
        end

        // Full scale q, keys from all 127 through mixes to all -128
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < `ATTN_DIM; i++) begin
                q[i] = (r == 0) ? elem_t'(127) : elem_t'(-128);
            end
            for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
                for (int i = 0; i < `ATTN_DIM; i++) begin
                    keys[j][i] = (((j >> (i % 3)) & 1) == 1) ? elem_t'(-128) : elem_t'(127);
                end
            end
            run_model_row(q, keys);
        end

        // Random rows, small and full range in turn
        for (int r = 0; r < NUM_ROWS - 6; r++) begin
            q = random_vec(r % 2 == 1);
            for (int j = 0; j < `ATTN_SEQ_LEN; j++) begin
                keys[j] = random_vec(r % 2 == 1);
            end
            run_model_row(q, keys);
        end

        while (rows_out < NUM_ROWS) @(negedge clk);
        repeat (4) @(negedge clk);
        if (exp_queue.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_error("expected results left over after the last row");
        end
    end

endmodule

`default_nettype wire

// File: attention_head.f
+incdir+.
attn_pkg.sv
score_matmul.sv
row_buffer.sv
softmax_row.sv
attention_head.sv
tb_clock.sv
tb_attention_head.sv

// File: Makefile
# Verilator build and run for the attention head testbench

VERILATOR ?= verilator
TOP       ?= tb_attention_head
FILELIST  ?= attention_head.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
